/* isa_pkg.sv */
package isa_pkg;

    // major opcode lives in inst[6:2]
    localparam int opcode_lsb = 2;
    localparam int opcode_w = 5;
    localparam int rd_lsb = 7;

    localparam logic [opcode_w-1:0] op_load = 5'b00000;
    localparam logic [opcode_w-1:0] op_fload = 5'b00001;
    localparam logic [opcode_w-1:0] op_store = 5'b01000;
    localparam logic [opcode_w-1:0] op_fstore = 5'b01001;

    // no rd field
    localparam logic [opcode_w-1:0] op_branch = 5'b11000;

endpackage

/* core_pkg.sv */
package core_pkg;

    // reorder buffer slots
    localparam int rob_depth = 8;

    // physical register file size, p0 is tied to x0
    localparam int preg_count = 128;

    localparam int areg_count = 32;

    // instruction and pc width
    localparam int xlen = 32;

endpackage

/* free_list.sv */
`timescale 1ns/1ps

module free_list #(
    parameter int n_preg = core_pkg::preg_count
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dispatch_fire,
    input  logic                      needs_preg,
    input  logic                      commit_wb_en,
    input  logic [$clog2(n_preg)-1:0] commit_p_rd_old,
    input  logic                      recovery,
    output logic                      free_avail,
    output logic [$clog2(n_preg)-1:0] p_rd_new_head
);

    localparam int pw = $clog2(n_preg);
    localparam int depth = n_preg - core_pkg::areg_count;
    localparam int iw = $clog2(depth);

    logic [pw-1:0] regs [depth];

    // wrap bit on top of the slot index
    logic [iw:0] spec_head;
    logic [iw:0] cmt_head;
    logic [iw:0] tail;

    function automatic logic [iw:0] ptr_next(input logic [iw:0] p);
        logic [iw:0] n;
        if (p[iw-1:0] == iw'(depth - 1)) begin
            n = {~p[iw], {iw{1'b0}}};
        end else begin
            n = p + 1'b1;
        end
        return n;
    endfunction

    assign free_avail = spec_head != tail;
    assign p_rd_new_head = regs[spec_head[iw-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            spec_head <= '0;
            cmt_head <= '0;
            // starts full with the registers above the architectural set
            tail <= {1'b1, {iw{1'b0}}};
            for (int i = 0; i < depth; i++) begin
                regs[i] <= pw'(core_pkg::areg_count + i);
            end
        end else begin
            // rewind hands back everything taken by flushed instructions
            if (recovery) begin
                spec_head <= cmt_head;
            end else if (dispatch_fire && needs_preg) begin
                spec_head <= ptr_next(spec_head);
            end
            if (commit_wb_en) begin
                regs[tail[iw-1:0]] <= commit_p_rd_old;
                tail <= ptr_next(tail);
                cmt_head <= ptr_next(cmt_head);
            end
        end
    end

endmodule

/* rename_table.sv */
`timescale 1ns/1ps

module rename_table #(
    parameter int n_preg = core_pkg::preg_count
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [core_pkg::xlen-1:0]               dispatch_inst,
    input  logic                                    dispatch_fire,
    input  logic [$clog2(n_preg)-1:0]               p_rd_new_head,
    input  logic                                    commit_wb_en,
    input  logic [$clog2(core_pkg::areg_count)-1:0] commit_a_rd,
    input  logic [$clog2(n_preg)-1:0]               commit_p_rd_new,
    input  logic                                    recovery,
    output logic                                    needs_preg,
    output logic [$clog2(n_preg)-1:0]               dispatch_p_rd_new,
    output logic [$clog2(n_preg)-1:0]               dispatch_p_rd_old
);

    localparam int pw = $clog2(n_preg);
    localparam int aw = $clog2(core_pkg::areg_count);

    logic [pw-1:0] spec_map [core_pkg::areg_count];
    logic [pw-1:0] cmt_map [core_pkg::areg_count];

    logic [aw-1:0] a_rd;
    logic [isa_pkg::opcode_w-1:0] opcode;
    logic writes_rd;

    assign a_rd = dispatch_inst[isa_pkg::rd_lsb +: aw];
    assign opcode = dispatch_inst[isa_pkg::opcode_lsb +: isa_pkg::opcode_w];

    // branches and stores reuse the rd bits as immediate
    assign writes_rd = !(opcode == isa_pkg::op_branch ||
                         opcode == isa_pkg::op_store ||
                         opcode == isa_pkg::op_fstore);

    // x0 never gets a new register, so it stays on p0
    assign needs_preg = writes_rd && (a_rd != '0);

    assign dispatch_p_rd_new = needs_preg ? p_rd_new_head : '0;
    assign dispatch_p_rd_old = spec_map[a_rd];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < core_pkg::areg_count; i++) begin
                spec_map[i] <= pw'(i);
                cmt_map[i] <= pw'(i);
            end
        end else begin
            if (recovery) begin
                // back to the last committed state
                for (int i = 0; i < core_pkg::areg_count; i++) begin
                    spec_map[i] <= cmt_map[i];
                end
            end else if (dispatch_fire && needs_preg) begin
                spec_map[a_rd] <= p_rd_new_head;
            end
            if (commit_wb_en) begin
                cmt_map[commit_a_rd] <= commit_p_rd_new;
            end
        end
    end

endmodule

/* rob.sv */
`timescale 1ns/1ps

module rob #(
    parameter int n_rob = core_pkg::rob_depth,
    parameter int n_preg = core_pkg::preg_count
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    dispatch_valid,
    input  logic [core_pkg::xlen-1:0]               dispatch_pc,
    input  logic [core_pkg::xlen-1:0]               dispatch_inst,
    input  logic [$clog2(n_preg)-1:0]               dispatch_p_rd_new,
    input  logic [$clog2(n_preg)-1:0]               dispatch_p_rd_old,
    input  logic                                    free_avail,
    input  logic                                    needs_preg,
    input  logic                                    rr_valid,
    input  logic [$clog2(n_rob)-1:0]                rr_rob_idx,
    input  logic                                    writeback_free,
    input  logic                                    wb_valid,
    input  logic [$clog2(n_rob)-1:0]                wb_rob_idx,
    input  logic                                    mispredict,
    input  logic [$clog2(n_rob)-1:0]                mis_rob_idx,
    output logic                                    dispatch_ready,
    output logic                                    dispatch_fire,
    output logic [$clog2(n_rob)-1:0]                dispatch_rob_idx,
    output logic [n_rob-1:0]                        flush_mask,
    output logic                                    commit,
    output logic                                    commit_wb_en,
    output logic [$clog2(n_rob)-1:0]                commit_rob_idx,
    output logic [core_pkg::xlen-1:0]               commit_pc,
    output logic [$clog2(core_pkg::areg_count)-1:0] commit_a_rd,
    output logic [$clog2(n_preg)-1:0]               commit_p_rd_new,
    output logic [$clog2(n_preg)-1:0]               commit_p_rd_old,
    output logic                                    ld_commit,
    output logic                                    st_commit,
    output logic                                    stall,
    output logic                                    recovery
);

    localparam int iw = $clog2(n_rob);
    localparam int pw = $clog2(n_preg);
    localparam int aw = $clog2(core_pkg::areg_count);

    typedef enum logic [1:0] {
        st_normal,
        st_pending,
        st_recover
    } rec_state_t;

    logic [iw-1:0] head;
    logic [iw-1:0] tail;

    logic [n_rob-1:0] slot_disp;
    logic [n_rob-1:0] slot_issued;
    logic [n_rob-1:0] slot_written;

    logic [core_pkg::xlen-1:0] slot_pc [n_rob];
    logic [isa_pkg::opcode_w-1:0] slot_op [n_rob];
    logic [aw-1:0] slot_a_rd [n_rob];
    logic [pw-1:0] slot_p_new [n_rob];
    logic [pw-1:0] slot_p_old [n_rob];

    logic full;
    logic empty;
    logic [isa_pkg::opcode_w-1:0] head_op;
    logic [n_rob-1:0] above_head;
    logic [n_rob-1:0] below_mis;
    rec_state_t state;
    rec_state_t state_next;

    assign full = (head == tail) && slot_disp[head];
    assign empty = (head == tail) && !slot_disp[head];

    assign dispatch_ready = !full && !stall && (free_avail || !needs_preg);
    assign dispatch_fire = dispatch_valid && dispatch_ready;
    assign dispatch_rob_idx = tail;

    assign head_op = slot_op[head];
    assign commit = slot_disp[head] && slot_written[head];
    assign commit_wb_en = commit && (slot_p_new[head] != '0);
    assign commit_rob_idx = head;
    assign commit_pc = slot_pc[head];
    assign commit_a_rd = slot_a_rd[head];
    assign commit_p_rd_new = slot_p_new[head];
    assign commit_p_rd_old = slot_p_old[head];
    assign ld_commit = commit && (head_op == isa_pkg::op_load || head_op == isa_pkg::op_fload);
    assign st_commit = commit && (head_op == isa_pkg::op_store || head_op == isa_pkg::op_fstore);

    // keep head..mis_rob_idx circularly, flush the rest
    always_comb begin
        for (int i = 0; i < n_rob; i++) begin
            above_head[i] = iw'(i) >= head;
            below_mis[i] = iw'(i) <= mis_rob_idx;
            if (head <= mis_rob_idx) begin
                flush_mask[i] = mispredict && !(above_head[i] && below_mis[i]);
            end else begin
                flush_mask[i] = mispredict && !(above_head[i] || below_mis[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            slot_disp <= '0;
            slot_issued <= '0;
            slot_written <= '0;
        end else begin
            if (mispredict) begin
                tail <= mis_rob_idx + 1'b1;
            end else if (dispatch_fire) begin
                tail <= tail + 1'b1;
            end
            if (commit) begin
                head <= head + 1'b1;
            end
            for (int i = 0; i < n_rob; i++) begin
                if (flush_mask[i] || (commit && head == iw'(i))) begin
                    slot_disp[i] <= 1'b0;
                    slot_issued[i] <= 1'b0;
                    slot_written[i] <= 1'b0;
                end else begin
                    if (dispatch_fire && tail == iw'(i)) begin
                        slot_disp[i] <= 1'b1;
                    end
                    // an instruction issues once
                    if (rr_valid && rr_rob_idx == iw'(i) && slot_disp[i] && !slot_issued[i]) begin
                        slot_issued[i] <= 1'b1;
                        if (writeback_free) begin
                            slot_written[i] <= 1'b1;
                        end
                    end
                    if (wb_valid && wb_rob_idx == iw'(i) && slot_disp[i]) begin
                        slot_written[i] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_fire) begin
            slot_pc[tail] <= dispatch_pc;
            slot_op[tail] <= dispatch_inst[isa_pkg::opcode_lsb +: isa_pkg::opcode_w];
            slot_a_rd[tail] <= dispatch_inst[isa_pkg::rd_lsb +: aw];
            slot_p_new[tail] <= dispatch_p_rd_new;
            slot_p_old[tail] <= dispatch_p_rd_old;
        end
    end

    // recovery waits for the older slots to drain
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_normal;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        unique case (state)
            st_normal: state_next = mispredict ? st_pending : st_normal;
            st_pending: state_next = empty ? st_recover : st_pending;
            st_recover: state_next = st_normal;
            default: state_next = st_normal;
        endcase
    end

    assign stall = state != st_normal;
    assign recovery = state == st_recover;

endmodule

/* rename_commit_top.sv */
`timescale 1ns/1ps

module rename_commit_top #(
    parameter int n_rob = core_pkg::rob_depth,
    parameter int n_preg = core_pkg::preg_count
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    dispatch_valid,
    input  logic [core_pkg::xlen-1:0]               dispatch_pc,
    input  logic [core_pkg::xlen-1:0]               dispatch_inst,
    output logic                                    dispatch_ready,
    output logic [$clog2(n_rob)-1:0]                dispatch_rob_idx,
    output logic [$clog2(n_preg)-1:0]               dispatch_p_rd_new,
    output logic [$clog2(n_preg)-1:0]               dispatch_p_rd_old,
    input  logic                                    rr_valid,
    input  logic [$clog2(n_rob)-1:0]                rr_rob_idx,
    input  logic                                    writeback_free,
    input  logic                                    wb_valid,
    input  logic [$clog2(n_rob)-1:0]                wb_rob_idx,
    input  logic                                    mispredict,
    input  logic [$clog2(n_rob)-1:0]                mis_rob_idx,
    output logic [n_rob-1:0]                        flush_mask,
    output logic                                    commit,
    output logic [$clog2(n_rob)-1:0]                commit_rob_idx,
    output logic [core_pkg::xlen-1:0]               commit_pc,
    output logic [$clog2(core_pkg::areg_count)-1:0] commit_a_rd,
    output logic [$clog2(n_preg)-1:0]               commit_p_rd_new,
    output logic [$clog2(n_preg)-1:0]               commit_p_rd_old,
    output logic                                    ld_commit,
    output logic                                    st_commit,
    output logic                                    stall,
    output logic                                    recovery
);

    localparam int pw = $clog2(n_preg);

    logic dispatch_fire;
    logic needs_preg;
    logic free_avail;
    logic [pw-1:0] p_rd_new_head;
    logic commit_wb_en;

    rename_table #(
        .n_preg(n_preg)
    ) rename_table_inst (
        .clk(clk),
        .rst(rst),
        .dispatch_inst(dispatch_inst),
        .dispatch_fire(dispatch_fire),
        .p_rd_new_head(p_rd_new_head),
        .commit_wb_en(commit_wb_en),
        .commit_a_rd(commit_a_rd),
        .commit_p_rd_new(commit_p_rd_new),
        .recovery(recovery),
        .needs_preg(needs_preg),
        .dispatch_p_rd_new(dispatch_p_rd_new),
        .dispatch_p_rd_old(dispatch_p_rd_old)
    );

    free_list #(
        .n_preg(n_preg)
    ) free_list_inst (
        .clk(clk),
        .rst(rst),
        .dispatch_fire(dispatch_fire),
        .needs_preg(needs_preg),
        .commit_wb_en(commit_wb_en),
        .commit_p_rd_old(commit_p_rd_old),
        .recovery(recovery),
        .free_avail(free_avail),
        .p_rd_new_head(p_rd_new_head)
    );

    rob #(
        .n_rob(n_rob),
        .n_preg(n_preg)
    ) rob_inst (
        .clk(clk),
        .rst(rst),
        .dispatch_valid(dispatch_valid),
        .dispatch_pc(dispatch_pc),
        .dispatch_inst(dispatch_inst),
        .dispatch_p_rd_new(dispatch_p_rd_new),
        .dispatch_p_rd_old(dispatch_p_rd_old),
        .free_avail(free_avail),
        .needs_preg(needs_preg),
        .rr_valid(rr_valid),
        .rr_rob_idx(rr_rob_idx),
        .writeback_free(writeback_free),
        .wb_valid(wb_valid),
        .wb_rob_idx(wb_rob_idx),
        .mispredict(mispredict),
        .mis_rob_idx(mis_rob_idx),
        .dispatch_ready(dispatch_ready),
        .dispatch_fire(dispatch_fire),
        .dispatch_rob_idx(dispatch_rob_idx),
        .flush_mask(flush_mask),
        .commit(commit),
        .commit_wb_en(commit_wb_en),
        .commit_rob_idx(commit_rob_idx),
        .commit_pc(commit_pc),
        .commit_a_rd(commit_a_rd),
        .commit_p_rd_new(commit_p_rd_new),
        .commit_p_rd_old(commit_p_rd_old),
        .ld_commit(ld_commit),
        .st_commit(st_commit),
        .stall(stall),
        .recovery(recovery)
    );

endmodule

/* rob_properties.sv */
`timescale 1ns/1ps

module rob_properties #(
    parameter int n_rob = core_pkg::rob_depth
) (
    input logic                     clk,
    input logic                     rst,
    input logic                     recovery,
    input logic [n_rob-1:0]         slot_disp,
    input logic [$clog2(n_rob)-1:0] head,
    input logic [$clog2(n_rob)-1:0] tail
);

    int assert_errors = 0;

    // map copy is only safe once everything has drained
    recovery_on_empty: assert property (@(posedge clk) disable iff (rst)
        recovery |-> slot_disp == '0)
        else begin
            $error("recovery while the reorder buffer still holds instructions");
            assert_errors++;
        end

    // oldest live instruction always sits at head
    head_is_oldest: assert property (@(posedge clk) disable iff (rst)
        slot_disp != '0 |-> slot_disp[head])
        else begin
            $error("reorder buffer holds instructions but the head slot is empty");
            assert_errors++;
        end

    tail_free_unless_full: assert property (@(posedge clk) disable iff (rst)
        slot_disp[tail] |-> head == tail)
        else begin
            $error("tail slot occupied while the reorder buffer is not full");
            assert_errors++;
        end

endmodule

bind rob rob_properties #(
    .n_rob(n_rob)
) rob_properties_inst (
    .clk(clk),
    .rst(rst),
    .recovery(recovery),
    .slot_disp(slot_disp),
    .head(head),
    .tail(tail)
);

/* tb_rename_commit.sv */
`timescale 1ns/1ps

module tb_rename_commit;

    localparam int n_rob = core_pkg::rob_depth;
    localparam int n_preg = core_pkg::preg_count;
    localparam int iw = $clog2(n_rob);
    localparam int pw = $clog2(n_preg);
    localparam int aw = $clog2(core_pkg::areg_count);

    logic clk;
    logic rst;
    logic dispatch_valid;
    logic [core_pkg::xlen-1:0] dispatch_pc;
    logic [core_pkg::xlen-1:0] dispatch_inst;
    logic dispatch_ready;
    logic [iw-1:0] dispatch_rob_idx;
    logic [pw-1:0] dispatch_p_rd_new;
    logic [pw-1:0] dispatch_p_rd_old;
    logic rr_valid;
    logic [iw-1:0] rr_rob_idx;
    logic writeback_free;
    logic wb_valid;
    logic [iw-1:0] wb_rob_idx;
    logic mispredict;
    logic [iw-1:0] mis_rob_idx;
    logic [n_rob-1:0] flush_mask;
    logic commit;
    logic [iw-1:0] commit_rob_idx;
    logic [core_pkg::xlen-1:0] commit_pc;
    logic [aw-1:0] commit_a_rd;
    logic [pw-1:0] commit_p_rd_new;
    logic [pw-1:0] commit_p_rd_old;
    logic ld_commit;
    logic st_commit;
    logic stall;
    logic recovery;

    int errors;
    int checks;
    int line_count;
    int limit_cycles;
    int fd;
    int assert_fails;
    logic [8*128-1:0] text;

    rename_commit_top #(
        .n_rob(n_rob),
        .n_preg(n_preg)
    ) rename_commit_top_inst (
        .*
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] got);
        checks++;
        if (expected !== got) begin
            errors++;
            $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, expected, got);
        end
    endtask

    task automatic idle_inputs();
        dispatch_valid = 1'b0;
        dispatch_pc = '0;
        dispatch_inst = '0;
        rr_valid = 1'b0;
        rr_rob_idx = '0;
        writeback_free = 1'b0;
        wb_valid = 1'b0;
        wb_rob_idx = '0;
        mispredict = 1'b0;
        mis_rob_idx = '0;
    endtask

    task automatic apply_command(input logic [63:0] cmd, input logic [31:0] a,
                                 input logic [31:0] b);
        idle_inputs();
        if (cmd == "D") begin
            dispatch_valid = 1'b1;
            dispatch_pc = a;
            dispatch_inst = b;
        end else if (cmd == "I") begin
            rr_valid = 1'b1;
            rr_rob_idx = a[iw-1:0];
            writeback_free = b[0];
        end else if (cmd == "W") begin
            wb_valid = 1'b1;
            wb_rob_idx = a[iw-1:0];
        end else if (cmd == "M") begin
            mispredict = 1'b1;
            mis_rob_idx = a[iw-1:0];
        end else if (cmd != "N") begin
            errors++;
            $display("unknown command %s in the tests file", cmd);
        end
    endtask

    // one line per cycle, outputs sampled at the falling edge
    task automatic run_tests();
        logic [63:0] cmd;
        logic [31:0] a, b, c;
        logic [31:0] e_ready, e_idx, e_new, e_old;
        logic [31:0] e_cmt, e_cidx, e_cpc, e_card, e_cnew, e_cold;
        logic [31:0] e_ld, e_st, e_flush, e_stall, e_rec;
        int n;
        n = $fscanf(fd, " %s", cmd);
        while (n == 1) begin
            if (cmd == "#") begin
                n = $fgets(text, fd);
            end else begin
                n = $fscanf(fd, " %h %h %h %d %d %d %d %d %d %h %d %d %d %d %d %h %d %d",
                            a, b, c, e_ready, e_idx, e_new, e_old, e_cmt, e_cidx, e_cpc,
                            e_card, e_cnew, e_cold, e_ld, e_st, e_flush, e_stall, e_rec);
                if (n != 18) begin
                    errors++;
                    $display("malformed line in the tests file after command %s", cmd);
                    break;
                end
                apply_command(cmd, a, b);
                @(negedge clk);
                check_value("dispatch_ready", e_ready, dispatch_ready);
                if (cmd == "D") begin
                    check_value("dispatch_rob_idx", e_idx, dispatch_rob_idx);
                    check_value("dispatch_p_rd_new", e_new, dispatch_p_rd_new);
                    check_value("dispatch_p_rd_old", e_old, dispatch_p_rd_old);
                end
                check_value("commit", e_cmt, commit);
                if (e_cmt != 0) begin
                    check_value("commit_rob_idx", e_cidx, commit_rob_idx);
                    check_value("commit_pc", e_cpc, commit_pc);
                    check_value("commit_a_rd", e_card, commit_a_rd);
                    check_value("commit_p_rd_new", e_cnew, commit_p_rd_new);
                    check_value("commit_p_rd_old", e_cold, commit_p_rd_old);
                end
                check_value("ld_commit", e_ld, ld_commit);
                check_value("st_commit", e_st, st_commit);
                check_value("flush_mask", e_flush, flush_mask);
                check_value("stall", e_stall, stall);
                check_value("recovery", e_rec, recovery);
                @(posedge clk);
                #1;
            end
            n = $fscanf(fd, " %s", cmd);
        end
    endtask

    // watchdog, sized from the tests file
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the test sequence did not finish within %0d cycles", limit_cycles);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        errors = 0;
        checks = 0;
        line_count = 0;
        rst = 1'b1;
        idle_inputs();
        fd = $fopen("rename_commit_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open rename_commit_tests.txt");
        end else begin
            while ($fgets(text, fd) != 0) begin
                line_count++;
            end
            $fclose(fd);
            limit_cycles = line_count * 20 + 200;
            fd = $fopen("rename_commit_tests.txt", "r");
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        if (fd != 0) begin
            run_tests();
            $fclose(fd);
        end
        idle_inputs();
        repeat (2) @(posedge clk);
        assert_fails = rename_commit_top_inst.rob_inst.rob_properties_inst.assert_errors;
        $display("%0d checks, %0d value errors, %0d assertion errors",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* rename_commit_tests.txt */
# cmd a b c | ready idx p_new p_old | commit c_idx c_pc c_a_rd c_p_new c_p_old ld st | flush stall rec
# a b c hex: D pc inst, I idx wb_free, W idx, M idx; c_pc and flush hex, the rest decimal
# renames, re-rename of x5, store, x0 and branch
D 100 2b3 0  1 0 32 5   0 0 0 0 0 0 0 0  00 0 0
D 104 303 0  1 1 33 6   0 0 0 0 0 0 0 0  00 0 0
D 108 2b3 0  1 2 34 32  0 0 0 0 0 0 0 0  00 0 0
D 10c 23 0   1 3 0 0    0 0 0 0 0 0 0 0  00 0 0
D 110 33 0   1 4 0 0    0 0 0 0 0 0 0 0  00 0 0
D 114 63 0   1 5 0 0    0 0 0 0 0 0 0 0  00 0 0
D 118 393 0  1 6 35 7   0 0 0 0 0 0 0 0  00 0 0
# writebacks in reverse, slot 3 written by its issue
W 6 0 0      1 0 0 0    0 0 0 0 0 0 0 0  00 0 0
W 5 0 0      1 0 0 0    0 0 0 0 0 0 0 0  00 0 0
W 4 0 0      1 0 0 0    0 0 0 0 0 0 0 0  00 0 0
I 3 1 0      1 0 0 0    0 0 0 0 0 0 0 0  00 0 0
W 2 0 0      1 0 0 0    0 0 0 0 0 0 0 0  00 0 0
W 1 0 0      1 0 0 0    0 0 0 0 0 0 0 0  00 0 0
W 0 0 0      1 0 0 0    0 0 0 0 0 0 0 0  00 0 0
N 0 0 0      1 0 0 0    1 0 100 5 32 5 0 0   00 0 0
N 0 0 0      1 0 0 0    1 1 104 6 33 6 1 0   00 0 0
N 0 0 0      1 0 0 0    1 2 108 5 34 32 0 0  00 0 0
N 0 0 0      1 0 0 0    1 3 10c 0 0 0 0 1    00 0 0
N 0 0 0      1 0 0 0    1 4 110 0 0 0 0 0    00 0 0
N 0 0 0      1 0 0 0    1 5 114 0 0 0 0 0    00 0 0
N 0 0 0      1 0 0 0    1 6 118 7 35 7 0 0   00 0 0
# fill all eight slots
D 200 533 0  1 7 36 10  0 0 0 0 0 0 0 0  00 0 0
D 204 5b3 0  1 0 37 11  0 0 0 0 0 0 0 0  00 0 0
D 208 633 0  1 1 38 12  0 0 0 0 0 0 0 0  00 0 0
D 20c 6b3 0  1 2 39 13  0 0 0 0 0 0 0 0  00 0 0
D 210 733 0  1 3 40 14  0 0 0 0 0 0 0 0  00 0 0
D 214 7b3 0  1 4 41 15  0 0 0 0 0 0 0 0  00 0 0
D 218 833 0  1 5 42 16  0 0 0 0 0 0 0 0  00 0 0
D 21c 8b3 0  1 6 43 17  0 0 0 0 0 0 0 0  00 0 0
D 220 933 0  0 7 44 18  0 0 0 0 0 0 0 0  00 0 0
W 7 0 0      0 0 0 0    0 0 0 0 0 0 0 0  00 0 0
N 0 0 0      0 0 0 0    1 7 200 10 36 10 0 0  00 0 0
D 220 933 0  1 7 44 18  0 0 0 0 0 0 0 0  00 0 0
# drain to a head of 6
W 0 0 0      0 0 0 0    0 0 0 0 0 0 0 0  00 0 0
W 1 0 0      0 0 0 0    1 0 204 11 37 11 0 0  00 0 0
W 2 0 0      1 0 0 0    1 1 208 12 38 12 0 0  00 0 0
W 3 0 0      1 0 0 0    1 2 20c 13 39 13 0 0  00 0 0
W 4 0 0      1 0 0 0    1 3 210 14 40 14 0 0  00 0 0
W 5 0 0      1 0 0 0    1 4 214 15 41 15 0 0  00 0 0
N 0 0 0      1 0 0 0    1 5 218 16 42 16 0 0  00 0 0
# wrapped mispredict at slot 0 flushes slot 1
D 300 a33 0  1 0 45 20  0 0 0 0 0 0 0 0  00 0 0
D 304 2b3 0  1 1 46 34  0 0 0 0 0 0 0 0  00 0 0
M 0 0 0      1 0 0 0    0 0 0 0 0 0 0 0  3e 0 0
W 6 0 0      0 0 0 0    0 0 0 0 0 0 0 0  00 1 0
W 7 0 0      0 0 0 0    1 6 21c 17 43 17 0 0  00 1 0
W 0 0 0      0 0 0 0    1 7 220 18 44 18 0 0  00 1 0
N 0 0 0      0 0 0 0    1 0 300 20 45 20 0 0  00 1 0
N 0 0 0      0 0 0 0    0 0 0 0 0 0 0 0  00 1 0
N 0 0 0      0 0 0 0    0 0 0 0 0 0 0 0  00 1 1
D 308 2b3 0  1 1 46 34  0 0 0 0 0 0 0 0  00 0 0
# mispredict without wrap
D 30c 333 0  1 2 47 33  0 0 0 0 0 0 0 0  00 0 0
M 1 0 0      1 0 0 0    0 0 0 0 0 0 0 0  fd 0 0
W 1 0 0      0 0 0 0    0 0 0 0 0 0 0 0  00 1 0
N 0 0 0      0 0 0 0    1 1 308 5 46 34 0 0   00 1 0
N 0 0 0      0 0 0 0    0 0 0 0 0 0 0 0  00 1 0
N 0 0 0      0 0 0 0    0 0 0 0 0 0 0 0  00 1 1
D 310 333 0  1 2 47 33  0 0 0 0 0 0 0 0  00 0 0

/* all.f */
isa_pkg.sv
core_pkg.sv
free_list.sv
rename_table.sv
rob.sv
rename_commit_top.sv
rob_properties.sv
tb_rename_commit.sv

/* Bender.yml */
package:
  name: rename_commit

sources:
  - isa_pkg.sv
  - core_pkg.sv
  - free_list.sv
  - rename_table.sv
  - rob.sv
  - rename_commit_top.sv
  - target: simulation
    files:
      - rob_properties.sv
      - tb_rename_commit.sv
